/* Bender.yml */
package:
  name: bpu

sources:
  - include_dirs:
      - .
    files:
      - bpu_pkg.sv
      - tage_dir.sv
      - btb.sv
      - ras.sv
      - bpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - bpu_assert.sv
      - tb_bpu.sv

/* bpu_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module bpu_assert
    import bpu_pkg::*;
(
    input wire            clk,
    input wire            rst,
    input wire bpu_pred_t pred_i
);

    int fail_cnt = 0; // failed assertions so far

    // history comes out of reset cleared
    hist_clear_after_reset: assert property (
        @(posedge clk) $fell(rst) |=> pred_i.history == '0
    ) else begin
        $error("history not zero one cycle after reset release");
        fail_cnt++;
    end

    no_cf_not_taken: assert property (
        @(posedge clk) disable iff (rst) !pred_i.is_cf |-> !pred_i.taken
    ) else begin
        $error("taken prediction on a non control-flow instruction");
        fail_cnt++;
    end

    tagged_needs_cf: assert property (
        @(posedge clk) disable iff (rst) (pred_i.provider != PROV_BIM) |-> pred_i.is_cf
    ) else begin
        $error("tagged provider on a non control-flow instruction");
        fail_cnt++;
    end

endmodule

bind bpu_top bpu_assert u_assert (
    .clk    (clk),
    .rst    (rst),
    .pred_i (pred_o)
);

`default_nettype wire

/* bpu_consts.svh */
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

`default_nettype none

// datapath widths
`define BPU_XLEN 32
`define BPU_HIST_W 16 // global history length

// direction predictor tables
`define BPU_BIM_ENTRIES 512
`define BPU_TAGE_ENTRIES 256 // per tagged table
`define BPU_TAG_W 10
`define BPU_PTAG_W 6 // upper tag bits that are compared

// branch target buffer
`define BPU_BTB_ENTRIES 256
`define BPU_BTB_TAG_W 22

// return address stack
`define BPU_RAS_DEPTH 32

// rv32i control-flow opcodes
`define BPU_OP_BRANCH 7'b1100011
`define BPU_OP_JAL 7'b1101111
`define BPU_OP_JALR 7'b1100111

`default_nettype wire

`endif

/* bpu_pkg.sv */
`include "bpu_consts.svh"
`default_nettype none

package bpu_pkg;

    // conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rv_btype_t;

    // jal layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_jtype_t;

    // jalr and other immediate ops
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_itype_t;

    // one instruction word, three views
    typedef union packed {
        rv_btype_t b;
        rv_jtype_t j;
        rv_itype_t i;
    } rv_inst_u;

    typedef enum logic [1:0] {
        PROV_BIM = 2'd0,
        PROV_T0  = 2'd1, // short history table
        PROV_T1  = 2'd2  // long history table
    } provider_e;

    typedef struct packed {
        logic [`BPU_XLEN-1:0] pc;
        rv_inst_u             inst;
    } fetch_req_t;

    typedef struct packed {
        logic                   is_cf;
        logic                   taken;
        logic [`BPU_XLEN-1:0]   target;
        provider_e              provider;
        logic [`BPU_HIST_W-1:0] history; // history seen by the lookup
    } bpu_pred_t;

    // resolved control flow from execute
    typedef struct packed {
        logic                   valid;
        logic                   taken;
        logic                   correct;
        logic                   stall;
        logic [`BPU_XLEN-1:0]   pc;
        logic [`BPU_XLEN-1:0]   target;
        rv_inst_u               inst;
        logic [`BPU_HIST_W-1:0] history;
        provider_e              provider;
    } bpu_update_t;

    typedef struct packed {
        logic                 valid;
        logic [`BPU_XLEN-1:0] addr; // return address of the call
    } ras_push_t;

endpackage

`default_nettype wire

/* bpu_top.sv */
`timescale 1ns/10ps
`include "bpu_consts.svh"
`default_nettype none

module bpu_top
    import bpu_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire fetch_req_t  fetch_i,
    input  wire bpu_update_t upd_i,
    input  wire ras_push_t   push_i,
    output bpu_pred_t        pred_o
);

    rv_inst_u inst;
    assign inst = fetch_i.inst;

    // fetch side decode
    logic is_branch, is_jal, is_jalr, is_ret;
    logic [`BPU_XLEN-1:0] b_imm, j_imm, pc_seq;

    assign is_branch = inst.b.opcode == `BPU_OP_BRANCH;
    assign is_jal    = inst.j.opcode == `BPU_OP_JAL;
    assign is_jalr   = inst.i.opcode == `BPU_OP_JALR;

    // jalr x0, 0(ra) or 0(t0)
    assign is_ret = is_jalr && (inst.i.rd == 5'd0) && (inst.i.imm12 == 12'd0) &&
                    ((inst.i.rs1 == 5'd1) || (inst.i.rs1 == 5'd5));

    assign b_imm  = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign j_imm  = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11, inst.j.imm10_1, 1'b0};
    assign pc_seq = fetch_i.pc + 32'd4;

    // execute side, a resolving return pops the stack
    logic      upd_is_ret;
    logic      ras_pop;
    ras_push_t ras_push;

    assign upd_is_ret = (upd_i.inst.i.opcode == `BPU_OP_JALR) &&
                        ((upd_i.inst.i.rs1 == 5'd1) || (upd_i.inst.i.rs1 == 5'd5));
    assign ras_pop    = upd_i.valid && upd_i.taken && !upd_i.stall && upd_is_ret;

    assign ras_push.valid = push_i.valid && !upd_i.stall;
    assign ras_push.addr  = push_i.addr;

    logic                   tage_taken;
    provider_e              tage_prov;
    logic [`BPU_HIST_W-1:0] ghist;
    logic                   btb_hit;
    logic [`BPU_XLEN-1:0]   btb_target;
    logic [`BPU_XLEN-1:0]   ras_top;
    logic                   ras_nonempty;

    tage_dir u_tage (
        .clk        (clk),
        .rst        (rst),
        .pc_i       (fetch_i.pc),
        .upd_i      (upd_i),
        .taken_o    (tage_taken),
        .provider_o (tage_prov),
        .history_o  (ghist)
    );

    btb u_btb (
        .clk         (clk),
        .rst         (rst),
        .pc_i        (fetch_i.pc),
        .wr_en_i     (upd_i.valid && upd_i.taken), // every taken resolve refreshes
        .wr_pc_i     (upd_i.pc),
        .wr_target_i (upd_i.target),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    ras u_ras (
        .clk        (clk),
        .rst        (rst),
        .push_i     (ras_push),
        .pop_i      (ras_pop),
        .top_o      (ras_top),
        .nonempty_o (ras_nonempty)
    );

    always_comb begin
        pred_o.is_cf    = is_branch || is_jal || is_jalr;
        pred_o.taken    = 1'b0;
        pred_o.target   = pc_seq;
        pred_o.provider = PROV_BIM;
        pred_o.history  = ghist;

        if (is_ret) begin
            if (ras_nonempty) begin // empty stack falls through to pc+4
                pred_o.taken  = 1'b1;
                pred_o.target = ras_top;
            end
        end else if (is_jal) begin
            pred_o.taken  = 1'b1;
            pred_o.target = btb_hit ? btb_target : fetch_i.pc + j_imm;
        end else if (is_branch || is_jalr) begin
            pred_o.taken    = tage_taken;
            pred_o.provider = tage_prov;
            if (tage_taken) begin
                if (btb_hit) begin
                    pred_o.target = btb_target;
                end else if (is_branch) begin
                    pred_o.target = fetch_i.pc + b_imm;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* btb.sv */
`timescale 1ns/10ps
`include "bpu_consts.svh"
`default_nettype none

module btb (
    input  wire                 clk,
    input  wire                 rst,
    input  wire [`BPU_XLEN-1:0] pc_i,
    input  wire                 wr_en_i,
    input  wire [`BPU_XLEN-1:0] wr_pc_i,
    input  wire [`BPU_XLEN-1:0] wr_target_i,
    output logic                hit_o,
    output logic [`BPU_XLEN-1:0] target_o
);

    localparam int N  = `BPU_BTB_ENTRIES;
    localparam int IW = $clog2(N);
    localparam int TW = `BPU_BTB_TAG_W;

    logic [TW-1:0]        tag_mem    [N];
    logic [`BPU_XLEN-1:0] target_mem [N];
    logic [N-1:0]         valid_q;

    // word aligned index, everything above it is the tag
    logic [IW-1:0] rd_idx;
    logic [TW-1:0] rd_tag;
    logic [IW-1:0] wr_idx;
    logic [TW-1:0] wr_tag;

    assign rd_idx = pc_i[IW+1:2];
    assign rd_tag = pc_i[`BPU_XLEN-1 -: TW];
    assign wr_idx = wr_pc_i[IW+1:2];
    assign wr_tag = wr_pc_i[`BPU_XLEN-1 -: TW];

    assign hit_o    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign target_o = target_mem[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target payload
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= wr_target_i; // last taken target replaces the old one
        end
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
bpu_pkg.sv
tage_dir.sv
btb.sv
ras.sv
bpu_top.sv
bpu_assert.sv
tb_bpu.sv

/* ras.sv */
`timescale 1ns/10ps
`include "bpu_consts.svh"
`default_nettype none

module ras
    import bpu_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire ras_push_t       push_i,
    input  wire                  pop_i,
    output logic [`BPU_XLEN-1:0] top_o,
    output logic                 nonempty_o
);

    localparam int DEPTH = `BPU_RAS_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [`BPU_XLEN-1:0] stack_mem [DEPTH];

    // points at the next free slot, one extra bit to tell full from empty
    logic [AW:0] sp_q;
    logic [AW:0] sp_pop;
    logic [AW:0] sp_top;
    logic        do_pop;
    logic        do_push;

    assign do_pop = pop_i && (sp_q != '0); // empty pop is dropped

    // pop first, then the push lands on the freed slot
    assign sp_pop  = do_pop ? sp_q - 1'b1 : sp_q;
    assign do_push = push_i.valid && (sp_pop < DEPTH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else if (do_push) begin
            sp_q <= sp_pop + 1'b1;
        end else begin
            sp_q <= sp_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_mem[sp_pop[AW-1:0]] <= push_i.addr;
        end
    end

    assign sp_top     = sp_q - 1'b1;
    assign top_o      = stack_mem[sp_top[AW-1:0]]; // only meaningful when nonempty
    assign nonempty_o = sp_q != '0;

endmodule

`default_nettype wire

/* tage_dir.sv */
`timescale 1ns/10ps
`include "bpu_consts.svh"
`default_nettype none

module tage_dir
    import bpu_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire [`BPU_XLEN-1:0]    pc_i,
    input  wire bpu_update_t       upd_i,
    output logic                   taken_o,
    output provider_e              provider_o,
    output logic [`BPU_HIST_W-1:0] history_o
);

    localparam int HW     = `BPU_HIST_W;
    localparam int BIM_N  = `BPU_BIM_ENTRIES;
    localparam int TAGE_N = `BPU_TAGE_ENTRIES;
    localparam int BIM_IW = $clog2(BIM_N);
    localparam int TIW    = $clog2(TAGE_N);
    localparam int TW     = `BPU_TAG_W;
    localparam int PW     = `BPU_PTAG_W;

    // index and tag hashes, shared by lookup and training
    function automatic logic [TIW-1:0] t0_index(input logic [`BPU_XLEN-1:0] pc,
                                                 input logic [HW-1:0] h);
        return pc[TIW-1:0] ^ h[TIW-1:0];
    endfunction

    function automatic logic [TIW-1:0] t1_index(input logic [`BPU_XLEN-1:0] pc,
                                                input logic [HW-1:0] h);
        return pc[TIW-1:0] ^ h[HW-1 -: TIW];
    endfunction

    function automatic logic [TW-1:0] t0_tag_f(input logic [`BPU_XLEN-1:0] pc,
                                               input logic [HW-1:0] h);
        return pc[TIW +: TW] ^ h[HW-1 -: TW];
    endfunction

    function automatic logic [TW-1:0] t1_tag_f(input logic [`BPU_XLEN-1:0] pc,
                                               input logic [HW-1:0] h);
        return pc[TIW +: TW] ^ {{(TW-TIW){1'b0}}, h[TIW-1:0]};
    endfunction

    // 2-bit saturating counter step
    function automatic logic [1:0] ctr_step(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    logic [HW-1:0] ghist;
    logic [1:0]    bim_ctr [BIM_N];
    logic [1:0]    t0_ctr  [TAGE_N];
    logic [1:0]    t1_ctr  [TAGE_N];
    logic [TW-1:0] t0_tag  [TAGE_N];
    logic [TW-1:0] t1_tag  [TAGE_N];

    // lookup side
    logic [BIM_IW-1:0] l_bidx;
    logic [TIW-1:0]    l_t0_idx, l_t1_idx;
    logic [TW-1:0]     l_t0_tag, l_t1_tag;
    logic              t0_hit, t1_hit;

    assign l_bidx   = pc_i[BIM_IW:1]; // halfword aligned
    assign l_t0_idx = t0_index(pc_i, ghist);
    assign l_t1_idx = t1_index(pc_i, ghist);
    assign l_t0_tag = t0_tag_f(pc_i, ghist);
    assign l_t1_tag = t1_tag_f(pc_i, ghist);

    // partial tag match on the upper bits only
    assign t0_hit = t0_tag[l_t0_idx][TW-1 -: PW] == l_t0_tag[TW-1 -: PW];
    assign t1_hit = t1_tag[l_t1_idx][TW-1 -: PW] == l_t1_tag[TW-1 -: PW];

    always_comb begin
        if (t1_hit) begin // longest history wins
            taken_o    = t1_ctr[l_t1_idx][1];
            provider_o = PROV_T1;
        end else if (t0_hit) begin
            taken_o    = t0_ctr[l_t0_idx][1];
            provider_o = PROV_T0;
        end else begin
            taken_o    = bim_ctr[l_bidx][1];
            provider_o = PROV_BIM;
        end
    end

    assign history_o = ghist;

    // training side, hashed with the history the prediction used
    logic [BIM_IW-1:0] u_bidx;
    logic [TIW-1:0]    u_t0_idx, u_t1_idx;
    logic [TW-1:0]     u_t0_tag, u_t1_tag;
    logic [1:0]        alloc_ctr;
    logic [1:0]        reset_ctr;

    assign u_bidx    = upd_i.pc[BIM_IW:1];
    assign u_t0_idx  = t0_index(upd_i.pc, upd_i.history);
    assign u_t1_idx  = t1_index(upd_i.pc, upd_i.history);
    assign u_t0_tag  = t0_tag_f(upd_i.pc, upd_i.history);
    assign u_t1_tag  = t1_tag_f(upd_i.pc, upd_i.history);
    assign alloc_ctr = upd_i.taken ? 2'b10 : 2'b01; // weak toward outcome
    assign reset_ctr = upd_i.taken ? 2'b11 : 2'b00; // strong toward outcome

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < BIM_N; i++) begin
                bim_ctr[i] <= 2'b01;
            end
            for (int i = 0; i < TAGE_N; i++) begin
                t0_ctr[i] <= 2'b01;
                t1_ctr[i] <= 2'b01;
                t0_tag[i] <= '0;
                t1_tag[i] <= '0;
            end
        end else if (upd_i.valid) begin
            ghist           <= {ghist[HW-2:0], upd_i.taken};
            bim_ctr[u_bidx] <= ctr_step(bim_ctr[u_bidx], upd_i.taken); // always trained
            if (upd_i.correct) begin
                case (upd_i.provider)
                    PROV_T1: t1_ctr[u_t1_idx] <= ctr_step(t1_ctr[u_t1_idx], upd_i.taken);
                    PROV_T0: t0_ctr[u_t0_idx] <= ctr_step(t0_ctr[u_t0_idx], upd_i.taken);
                    default: ;
                endcase
            end else begin
                case (upd_i.provider)
                    PROV_T1: t1_ctr[u_t1_idx] <= reset_ctr;
                    PROV_T0: t0_ctr[u_t0_idx] <= reset_ctr;
                    default: begin
                        // base table missed, try T1 first
                        if (t1_tag[u_t1_idx] != u_t1_tag) begin
                            t1_tag[u_t1_idx] <= u_t1_tag;
                            t1_ctr[u_t1_idx] <= alloc_ctr;
                        end else if (t0_tag[u_t0_idx] != u_t0_tag) begin
                            t0_tag[u_t0_idx] <= u_t0_tag;
                            t0_ctr[u_t0_idx] <= alloc_ctr;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* tb_bpu.sv */
`timescale 1ns/10ps
`include "bpu_consts.svh"
`default_nettype none

module tb_bpu
    import bpu_pkg::*;
();

    localparam int MAX_CYCLES = 2000; // stimulus needs about 100 cycles
    localparam logic [31:0] NOP = 32'h0000_0013; // addi x0, x0, 0
    localparam logic [31:0] RET = 32'h0000_8067; // jalr x0, 0(x1)

    logic        clk = 1'b0;
    logic        rst;
    fetch_req_t  fetch_i;
    bpu_update_t upd_i;
    ras_push_t   push_i;
    bpu_pred_t   pred_o;

    int          seed = 18883;
    int          cycle_cnt = 0;
    int          err_cnt = 0;
    int          test_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       cur_test;
    logic [15:0] exp_hist = '0; // model of the global history

    bpu_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .fetch_i (fetch_i),
        .upd_i   (upd_i),
        .push_i  (push_i),
        .pred_o  (pred_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout, run still going after %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // beq x0, x0, imm
    function automatic logic [31:0] enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd0, 5'd0, 3'b000, imm[4:1], imm[11], `BPU_OP_BRANCH};
    endfunction

    // jal x1, imm
    function automatic logic [31:0] enc_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `BPU_OP_JAL};
    endfunction

    // bit 17 set keeps the upper tag bits off the all-zero reset tags
    function automatic logic [31:0] rand_pc();
        return ($random(seed) & 32'hffff_fffc) | 32'h0002_0000;
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error: %s %s expected %h, actual %h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = err_cnt;
    endtask

    task automatic report_test();
        tests_run++;
        if (err_cnt == test_errs) begin
            $display("%s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", cur_test, err_cnt - test_errs);
        end
    endtask

    // prediction is combinational, sampled mid cycle
    task automatic predict(input logic [31:0] pc, input logic [31:0] inst);
        fetch_req_t f;
        f.pc   = pc;
        f.inst = inst;
        @(posedge clk);
        fetch_i <= f;
        @(negedge clk);
    endtask

    task automatic apply_update(input logic [31:0] pc, input logic [31:0] tgt,
                                input logic [31:0] inst, input logic taken,
                                input logic correct, input logic [15:0] hist);
        bpu_update_t u;
        u          = '0;
        u.valid    = 1'b1;
        u.taken    = taken;
        u.correct  = correct;
        u.pc       = pc;
        u.target   = tgt;
        u.inst     = inst;
        u.history  = hist;
        u.provider = PROV_BIM;
        @(posedge clk);
        upd_i <= u;
        @(posedge clk);
        upd_i <= '0;
        exp_hist = {exp_hist[14:0], taken};
    endtask

    task automatic push_call(input logic [31:0] addr, input logic stall);
        ras_push_t   p;
        bpu_update_t u;
        p.valid = 1'b1;
        p.addr  = addr;
        u       = '0;
        u.stall = stall; // stall alone, no valid update
        @(posedge clk);
        push_i <= p;
        upd_i  <= u;
        @(posedge clk);
        push_i <= '0;
        upd_i  <= '0;
    endtask

    task automatic reset_state();
        logic [31:0] pc;
        pc = rand_pc();
        start_test("reset_state");
        predict(pc, NOP);
        compare("is_cf", 0, pred_o.is_cf);
        compare("taken", 0, pred_o.taken);
        compare("target", pc + 32'd4, pred_o.target);
        predict(pc, enc_branch(13'h0040));
        compare("is_cf", 1, pred_o.is_cf);
        compare("taken", 0, pred_o.taken);
        compare("target", pc + 32'd4, pred_o.target);
        compare("provider", PROV_BIM, pred_o.provider);
        compare("history", 0, pred_o.history);
        report_test();
    endtask

    task automatic jal_target();
        logic [31:0] pc;
        logic [31:0] x;
        pc = rand_pc();
        x  = $random(seed) & 32'hffff_fffc;
        start_test("jal_target");
        predict(pc, enc_jal(21'h1f_f800)); // offset -2048
        compare("taken", 1, pred_o.taken);
        compare("target", pc - 32'd2048, pred_o.target);
        apply_update(pc, x, enc_jal(21'h1f_f800), 1'b1, 1'b1, exp_hist);
        predict(pc, enc_jal(21'h1f_f800));
        compare("btb target", x, pred_o.target);
        report_test();
    endtask

    task automatic bimodal_train();
        logic [31:0] pc;
        logic [31:0] alias_pc;
        logic [31:0] br;
        pc       = rand_pc();
        alias_pc = pc ^ 32'h0010_0000; // same bimodal entry, btb tag differs
        br       = enc_branch(13'h1fe8); // offset -24
        start_test("bimodal_train");
        apply_update(pc, pc - 32'd24, br, 1'b1, 1'b1, exp_hist);
        apply_update(pc, pc - 32'd24, br, 1'b1, 1'b1, exp_hist);
        predict(pc, br);
        compare("taken", 1, pred_o.taken);
        compare("target", pc - 32'd24, pred_o.target);
        compare("provider", PROV_BIM, pred_o.provider);
        predict(alias_pc, br);
        compare("alias taken", 1, pred_o.taken);
        compare("alias b-imm target", alias_pc - 32'd24, pred_o.target);
        report_test();
    endtask

    task automatic t1_allocation();
        logic [31:0] pc;
        logic [31:0] br;
        logic [15:0] next_hist;
        pc        = rand_pc();
        br        = enc_branch(13'h0100);
        next_hist = {exp_hist[14:0], 1'b1};
        start_test("t1_allocation");
        apply_update(pc, pc + 32'd256, br, 1'b1, 1'b0, next_hist);
        predict(pc, br);
        compare("provider", PROV_T1, pred_o.provider);
        compare("taken", 1, pred_o.taken);
        compare("history", next_hist, pred_o.history);
        report_test();
    endtask

    task automatic return_stack();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        a  = rand_pc();
        b  = rand_pc();
        pc = rand_pc();
        start_test("return_stack");
        push_call(a, 1'b0);
        push_call(b, 1'b0);
        predict(pc, RET);
        compare("taken", 1, pred_o.taken);
        compare("target", b, pred_o.target);
        apply_update(pc, b, RET, 1'b1, 1'b1, exp_hist); // pops b
        predict(pc, RET);
        compare("target after pop", a, pred_o.target);
        push_call(b, 1'b1);
        predict(pc, RET);
        compare("target after stalled push", a, pred_o.target);
        apply_update(pc, a, RET, 1'b1, 1'b1, exp_hist);
        predict(pc, RET);
        compare("empty taken", 0, pred_o.taken);
        compare("empty target", pc + 32'd4, pred_o.target);
        report_test();
    endtask

    task automatic history_shift();
        start_test("history_shift");
        for (int i = 0; i < 20; i++) begin
            apply_update(rand_pc(), 32'h0, enc_branch(13'h0010), $random(seed) & 1, 1'b1,
                         exp_hist);
        end
        predict(rand_pc(), NOP);
        compare("history", exp_hist, pred_o.history);
        report_test();
    endtask

    initial begin
        rst     = 1'b1;
        fetch_i = '0;
        upd_i   = '0;
        push_i  = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        reset_state();
        jal_target();
        bimodal_train();
        t1_allocation();
        return_stack();
        history_shift();
        $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, err_cnt, u_dut.u_assert.fail_cnt);
        if (err_cnt == 0 && u_dut.u_assert.fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
